// ==== rtl/dp_pkg.sv ====
`default_nettype none

package dp_pkg;

    //////////////////////////////
    // sizes
    localparam int DATA_W        = 32;
    localparam int RES_W         = 16;
    localparam int ACC_W         = 24;
    localparam int CH_W          = 8;
    localparam int BIAS_DEPTH    = 256;
    localparam int IN_FIFO_DEPTH = 8;
    localparam int OUT_CREDITS   = 4;

    localparam int FIFO_PTR_W = $clog2(IN_FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(IN_FIFO_DEPTH + 1);
    localparam int CREDIT_W   = $clog2(OUT_CREDITS + 1);

    // saturation bounds, in accumulator width
    localparam logic signed [ACC_W-1:0] RES_MAX = (1 <<< (RES_W - 1)) - 1;
    localparam logic signed [ACC_W-1:0] RES_MIN = -(1 <<< (RES_W - 1));

    //////////////////////////////
    // encodings
    typedef enum logic [1:0] {
        OP_COMPUTE   = 2'd0,
        OP_LOAD_BIAS = 2'd1
    } op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD_BIAS,
        ST_BIAS_READ,
        ST_ACCUM,
        ST_EMIT,
        ST_DRAIN
    } state_e;

    //////////////////////////////
    // bundles
    typedef struct packed {
        logic            valid;
        op_e             op;
        logic [CH_W-1:0] in_ch;
        logic [CH_W-1:0] out_ch;
    } cmd_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } in_beat_t;

    typedef struct packed {
        logic              valid;
        logic              last;
        logic [DATA_W-1:0] data;
    } out_beat_t;

    typedef struct packed {
        logic             valid;
        logic             last;
        logic [RES_W-1:0] value;
    } res_t;

endpackage

`default_nettype wire

// ==== rtl/stream_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_fifo import dp_pkg::*; (
    input  wire logic              clk_i,
    input  wire logic              reset_i,
    input  wire in_beat_t          in_i,
    input  wire logic              pop_i,
    output logic [DATA_W-1:0]      data_o,
    output logic                   empty_o,
    output logic                   in_credit_o
);

    logic [DATA_W-1:0]     mem [IN_FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  push;
    logic                  pop_ok;

    // sender holds credits, full guard is only a backstop
    assign push    = in_i.valid && (count != FIFO_CNT_W'(IN_FIFO_DEPTH));
    assign pop_ok  = pop_i && !empty_o;
    assign empty_o = (count == '0);
    assign data_o  = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= in_i.data;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            in_credit_o <= 1'b0;
        end else begin
            in_credit_o <= pop_ok;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bias_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module bias_ram import dp_pkg::*; (
    input  wire logic             clk_i,
    input  wire logic             we_i,
    input  wire logic [CH_W-1:0]  addr_i,
    input  wire logic [RES_W-1:0] wdata_i,
    output logic      [RES_W-1:0] rdata_o
);

    logic [RES_W-1:0] mem [BIAS_DEPTH];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // registered read, one cycle after the address
    always_ff @(posedge clk_i) begin
        rdata_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

// ==== rtl/channel_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module channel_counter import dp_pkg::*; (
    input  wire logic            clk_i,
    input  wire logic            reset_i,
    input  wire logic            clear_i,
    input  wire logic            word_step_i,
    input  wire logic            chan_step_i,
    input  wire logic [CH_W-1:0] in_ch_i,
    input  wire logic [CH_W-1:0] out_ch_i,
    output logic      [CH_W-1:0] chan_idx_o,
    output logic                 word_last_o,
    output logic                 chan_last_o
);

    logic [CH_W-1:0] word_cnt;
    logic [CH_W-1:0] chan_cnt;
    logic [CH_W-1:0] in_ch_q;
    logic [CH_W-1:0] out_ch_q;

    assign word_last_o = (word_cnt == in_ch_q - CH_W'(1));
    assign chan_last_o = (chan_cnt == out_ch_q - CH_W'(1));
    assign chan_idx_o  = chan_cnt;

    // channel sizes captured with the command
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            word_cnt <= '0;
            chan_cnt <= '0;
            in_ch_q  <= '0;
            out_ch_q <= '0;
        end else if (clear_i) begin
            word_cnt <= '0;
            chan_cnt <= '0;
            in_ch_q  <= in_ch_i;
            out_ch_q <= out_ch_i;
        end else begin
            if (word_step_i) begin
                word_cnt <= word_last_o ? '0 : word_cnt + 1'b1;
            end
            if (chan_step_i) begin
                chan_cnt <= chan_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/layer_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module layer_ctrl_fsm import dp_pkg::*; (
    input  wire logic clk_i,
    input  wire logic reset_i,
    input  wire cmd_t cmd_i,
    input  wire logic fifo_empty_i,
    input  wire logic word_last_i,
    input  wire logic chan_last_i,
    input  wire logic pack_ready_i,
    input  wire logic out_idle_i,
    output logic      fifo_pop_o,
    output logic      bias_we_o,
    output logic      word_step_o,
    output logic      chan_step_o,
    output logic      cnt_clear_o,
    output logic      acc_start_o,
    output logic      acc_add_o,
    output logic      acc_close_o,
    output logic      busy_o
);

    state_e state_q;
    state_e state_n;
    logic   first_q;

    assign busy_o = (state_q != ST_IDLE);

    //////////////////////////////
    // next state and strobes
    always_comb begin
        state_n     = state_q;
        fifo_pop_o  = 1'b0;
        bias_we_o   = 1'b0;
        word_step_o = 1'b0;
        chan_step_o = 1'b0;
        cnt_clear_o = 1'b0;
        acc_start_o = 1'b0;
        acc_add_o   = 1'b0;
        acc_close_o = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (cmd_i.valid) begin
                    cnt_clear_o = 1'b1;
                    case (cmd_i.op)
                        OP_LOAD_BIAS: state_n = ST_LOAD_BIAS;
                        OP_COMPUTE:   state_n = ST_BIAS_READ;
                        default:      state_n = ST_IDLE;
                    endcase
                end
            end
            ST_LOAD_BIAS: begin
                // one bias per popped word
                if (!fifo_empty_i) begin
                    fifo_pop_o  = 1'b1;
                    bias_we_o   = 1'b1;
                    chan_step_o = 1'b1;
                    if (chan_last_i) begin
                        state_n = ST_DRAIN;
                    end
                end
            end
            ST_BIAS_READ: begin
                state_n = ST_ACCUM;
            end
            ST_ACCUM: begin
                // closing word waits for room in the packer
                if (!fifo_empty_i && (!word_last_i || pack_ready_i)) begin
                    fifo_pop_o  = 1'b1;
                    acc_add_o   = 1'b1;
                    word_step_o = 1'b1;
                    acc_start_o = first_q;
                    if (word_last_i) begin
                        acc_close_o = 1'b1;
                        chan_step_o = 1'b1;
                        state_n     = chan_last_i ? ST_EMIT : ST_BIAS_READ;
                    end
                end
            end
            ST_EMIT: begin
                state_n = ST_DRAIN;
            end
            ST_DRAIN: begin
                if (out_idle_i) begin
                    state_n = ST_IDLE;
                end
            end
            default: begin
                state_n = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            first_q <= 1'b0;
        end else begin
            state_q <= state_n;
            if (state_q == ST_BIAS_READ) begin
                first_q <= 1'b1;
            end else if (acc_add_o) begin
                first_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/psum_accum.sv ====
`timescale 1ns/1ps
`default_nettype none

module psum_accum import dp_pkg::*; (
    input  wire logic              clk_i,
    input  wire logic              reset_i,
    input  wire logic              start_i,
    input  wire logic              add_i,
    input  wire logic              close_i,
    input  wire logic              last_i,
    input  wire logic [RES_W-1:0]  bias_i,
    input  wire logic [DATA_W-1:0] data_i,
    output res_t                   res_o
);

    logic signed [ACC_W-1:0] acc_q;
    logic signed [ACC_W-1:0] bias_ext;
    logic signed [ACC_W-1:0] data_ext;
    logic signed [ACC_W-1:0] acc_base;
    logic signed [ACC_W-1:0] acc_n;
    logic        [RES_W-1:0] sat_val;
    logic                    res_valid_q;
    logic                    res_last_q;
    logic        [RES_W-1:0] res_val_q;

    always_comb begin
        bias_ext = {{(ACC_W - RES_W){bias_i[RES_W-1]}}, bias_i};
        data_ext = {{(ACC_W - RES_W){data_i[RES_W-1]}}, data_i[RES_W-1:0]};
        // start replaces the running sum with the bias
        acc_base = start_i ? bias_ext : acc_q;
        acc_n    = add_i ? acc_base + data_ext : acc_base;
        if (acc_n > RES_MAX) begin
            sat_val = RES_MAX[RES_W-1:0];
        end else if (acc_n < RES_MIN) begin
            sat_val = RES_MIN[RES_W-1:0];
        end else begin
            sat_val = acc_n[RES_W-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i || add_i) begin
            acc_q <= acc_n;
        end
        if (close_i) begin
            res_val_q  <= sat_val;
            res_last_q <= last_i;
        end
    end

    // valid is a one-cycle pulse, value stays until the next close
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= close_i;
        end
    end

    assign res_o.valid = res_valid_q;
    assign res_o.last  = res_last_q;
    assign res_o.value = res_val_q;

endmodule

`default_nettype wire

// ==== rtl/out_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module out_packer import dp_pkg::*; (
    input  wire logic clk_i,
    input  wire logic reset_i,
    input  wire res_t res_i,
    input  wire logic out_credit_i,
    output out_beat_t out_o,
    output logic      pack_ready_o,
    output logic      idle_o
);

    logic                half_v;
    logic [RES_W-1:0]    half_val;
    logic                pend_v;
    logic                pend_last;
    logic [DATA_W-1:0]   pend_data;
    logic [CREDIT_W-1:0] credit_q;
    logic                send;
    logic                form;

    assign send = pend_v && (credit_q != '0);
    // a word forms on the second result, or on a lone last one
    assign form = res_i.valid && (half_v || res_i.last);

    // next result lands one cycle after a close
    assign pack_ready_o = (!pend_v || send) && !res_i.valid;
    assign idle_o       = !half_v && !pend_v;

    always_comb begin
        out_o.valid = send;
        out_o.last  = pend_last;
        out_o.data  = pend_data;
    end

    always_ff @(posedge clk_i) begin
        if (res_i.valid && !form) begin
            half_val <= res_i.value;
        end
        if (form) begin
            pend_data <= half_v ? {res_i.value, half_val} : {{RES_W{1'b0}}, res_i.value};
            pend_last <= res_i.last;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            half_v   <= 1'b0;
            pend_v   <= 1'b0;
            credit_q <= CREDIT_W'(OUT_CREDITS);
        end else begin
            if (res_i.valid && !form) begin
                half_v <= 1'b1;
            end else if (form) begin
                half_v <= 1'b0;
            end
            if (form) begin
                pend_v <= 1'b1;
            end else if (send) begin
                pend_v <= 1'b0;
            end
            case ({send, out_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/conv_data_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_data_path import dp_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     reset_i,
    input  wire cmd_t     cmd_i,
    output logic          busy_o,
    input  wire in_beat_t in_i,
    output logic          in_credit_o,
    output out_beat_t     out_o,
    input  wire logic     out_credit_i
);

    logic [DATA_W-1:0] fifo_data;
    logic              fifo_empty;
    logic              fifo_pop;
    logic              bias_we;
    logic [RES_W-1:0]  bias_rdata;
    logic [CH_W-1:0]   chan_idx;
    logic              word_last;
    logic              chan_last;
    logic              word_step;
    logic              chan_step;
    logic              cnt_clear;
    logic              acc_start;
    logic              acc_add;
    logic              acc_close;
    res_t              res;
    logic              pack_ready;
    logic              out_idle;

    //////////////////////////////
    // input side
    stream_fifo u_stream_fifo (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .in_i        (in_i),
        .pop_i       (fifo_pop),
        .data_o      (fifo_data),
        .empty_o     (fifo_empty),
        .in_credit_o (in_credit_o)
    );

    // channel index doubles as bias address
    bias_ram u_bias_ram (
        .clk_i   (clk_i),
        .we_i    (bias_we),
        .addr_i  (chan_idx),
        .wdata_i (fifo_data[RES_W-1:0]),
        .rdata_o (bias_rdata)
    );

    channel_counter u_channel_counter (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .clear_i     (cnt_clear),
        .word_step_i (word_step),
        .chan_step_i (chan_step),
        .in_ch_i     (cmd_i.in_ch),
        .out_ch_i    (cmd_i.out_ch),
        .chan_idx_o  (chan_idx),
        .word_last_o (word_last),
        .chan_last_o (chan_last)
    );

    layer_ctrl_fsm u_layer_ctrl_fsm (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .cmd_i        (cmd_i),
        .fifo_empty_i (fifo_empty),
        .word_last_i  (word_last),
        .chan_last_i  (chan_last),
        .pack_ready_i (pack_ready),
        .out_idle_i   (out_idle),
        .fifo_pop_o   (fifo_pop),
        .bias_we_o    (bias_we),
        .word_step_o  (word_step),
        .chan_step_o  (chan_step),
        .cnt_clear_o  (cnt_clear),
        .acc_start_o  (acc_start),
        .acc_add_o    (acc_add),
        .acc_close_o  (acc_close),
        .busy_o       (busy_o)
    );

    //////////////////////////////
    // output side
    psum_accum u_psum_accum (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .start_i (acc_start),
        .add_i   (acc_add),
        .close_i (acc_close),
        .last_i  (chan_last),
        .bias_i  (bias_rdata),
        .data_i  (fifo_data),
        .res_o   (res)
    );

    out_packer u_out_packer (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .res_i        (res),
        .out_credit_i (out_credit_i),
        .out_o        (out_o),
        .pack_ready_o (pack_ready),
        .idle_o       (out_idle)
    );

endmodule

`default_nettype wire

// ==== verification/conv_data_path_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_data_path_assert import dp_pkg::*; (
    input wire logic      clk_i,
    input wire logic      reset_i,
    input wire logic      busy_o,
    input wire logic      in_credit_o,
    input wire out_beat_t out_o
);

    // count of failed assertions
    int fail_cnt = 0;

    //////////////////////////////
    // output stream
    a_no_valid_in_reset: assert property (@(posedge clk_i) reset_i |=> !out_o.valid)
        else begin
            fail_cnt++;
            $error("output valid right after a reset cycle");
        end

    a_no_valid_when_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        !busy_o |-> !out_o.valid)
        else begin
            fail_cnt++;
            $error("output valid while no command is running");
        end

    //////////////////////////////
    // input stream
    // no pops outside a command means a stray command does nothing
    a_no_credit_when_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        !busy_o |-> !in_credit_o)
        else begin
            fail_cnt++;
            $error("input credit returned while no command is running");
        end

endmodule

bind conv_data_path conv_data_path_assert u_assert (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .busy_o      (busy_o),
    .in_credit_o (in_credit_o),
    .out_o       (out_o)
);

`default_nettype wire

// ==== verification/tb_conv_data_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_conv_data_path import dp_pkg::*; ();

    localparam int WAIT_LIMIT = 20000;

    logic      clk = 1'b0;
    logic      reset;
    cmd_t      cmd;
    logic      busy;
    in_beat_t  in_beat;
    logic      in_credit;
    out_beat_t out_beat;
    logic      out_credit;

    logic [DATA_W-1:0]       send_q[$];
    logic [DATA_W-1:0]       exp_data_q[$];
    logic                    exp_last_q[$];
    out_beat_t               rx_q[$];
    logic signed [RES_W-1:0] bias_model [BIAS_DEPTH];

    int in_credits = IN_FIFO_DEPTH;
    int words_sent = 0;
    int credit_pulses = 0;
    int words_rx = 0;
    int credits_granted = 0;
    int owed = 0;
    int stall_left = 0;
    int stall_on = 0;
    int gap_pct = 30;
    int data_errs = 0;
    int last_errs = 0;
    int flow_errs = 0;
    int timeout_errs = 0;

    conv_data_path dut (
        .clk_i        (clk),
        .reset_i      (reset),
        .cmd_i        (cmd),
        .busy_o       (busy),
        .in_i         (in_beat),
        .in_credit_o  (in_credit),
        .out_o        (out_beat),
        .out_credit_i (out_credit)
    );

    always #4 clk = ~clk;

    //////////////////////////////
    // reference model
    function automatic logic signed [RES_W-1:0] ref_channel(
        input logic signed [RES_W-1:0] bias,
        input logic [DATA_W-1:0]       words[$]
    );
        int                      sum;
        int                      max_val;
        int                      min_val;
        logic signed [RES_W-1:0] v;
        max_val = (1 << (RES_W - 1)) - 1;
        min_val = -(1 << (RES_W - 1));
        sum = int'(bias);
        foreach (words[i]) begin
            v = words[i][RES_W-1:0];
            sum += int'(v);
        end
        if (sum > max_val) begin
            return RES_W'(max_val);
        end
        if (sum < min_val) begin
            return RES_W'(min_val);
        end
        return RES_W'(sum);
    endfunction

    //////////////////////////////
    // checks and reporting
    task automatic check_word(input out_beat_t got, input logic [DATA_W-1:0] exp);
        if (got.data !== exp) begin
            data_errs++;
            $display("** Error at %0t: out_o.data = %h, expected %h", $time, got.data, exp);
        end
    endtask

    task automatic check_last(input out_beat_t got, input logic exp);
        if (got.last !== exp) begin
            last_errs++;
            $display("** Error at %0t: out_o.last = %b, expected %b", $time, got.last, exp);
        end
    endtask

    task automatic check_low(input string name, input logic got);
        if (got !== 1'b0) begin
            flow_errs++;
            $display("** Error at %0t: %s = %b, expected 0", $time, name, got);
        end
    endtask

    task automatic report_and_finish();
        int total;
        int assert_errs;
        assert_errs = dut.u_assert.fail_cnt;
        total = data_errs + last_errs + flow_errs + timeout_errs + assert_errs;
        $display("error counts: data %0d, last %0d, flow %0d, timeout %0d, assert %0d",
                 data_errs, last_errs, flow_errs, timeout_errs, assert_errs);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        timeout_errs++;
        $display("timeout at %0t: %s", $time, what);
        report_and_finish();
    endtask

    //////////////////////////////
    // waits
    task automatic wait_not_busy();
        int t;
        t = 0;
        @(negedge clk);
        while (busy && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (busy) begin
            give_up("busy_o never fell");
        end
    endtask

    task automatic wait_results_done();
        int t;
        t = 0;
        while (exp_data_q.size() != 0 && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (exp_data_q.size() != 0) begin
            give_up("expected output words never arrived");
        end
    endtask

    //////////////////////////////
    // commands
    task automatic send_cmd(input op_e op, input int in_ch, input int out_ch);
        wait_not_busy();
        @(posedge clk);
        cmd.valid  <= 1'b1;
        cmd.op     <= op;
        cmd.in_ch  <= CH_W'(in_ch);
        cmd.out_ch <= CH_W'(out_ch);
        @(posedge clk);
        cmd.valid <= 1'b0;
    endtask

    task automatic load_biases(input int n);
        logic [DATA_W-1:0] b;
        for (int i = 0; i < n; i++) begin
            b = $urandom;
            bias_model[i] = b[RES_W-1:0];
            send_q.push_back(b);
        end
        // in_ch is don't care for a bias load
        send_cmd(OP_LOAD_BIAS, 1 + int'($urandom % 8), n);
        wait_not_busy();
    endtask

    // kind 1 drives every input to full scale for saturation
    task automatic run_layer(input int in_ch, input int out_ch, input int kind);
        logic [DATA_W-1:0]       word;
        logic [DATA_W-1:0]       chan_words[$];
        logic signed [RES_W-1:0] res;
        logic [RES_W-1:0]        low_half;
        low_half = '0;
        for (int c = 0; c < out_ch; c++) begin
            chan_words.delete();
            for (int w = 0; w < in_ch; w++) begin
                word = $urandom;
                if (kind == 1) begin
                    word[RES_W-1:0] = (c % 2 == 0) ? 16'h7fff : 16'h8000;
                end
                chan_words.push_back(word);
                send_q.push_back(word);
            end
            res = ref_channel(bias_model[c], chan_words);
            if (c % 2 == 0) begin
                low_half = res;
            end else begin
                exp_data_q.push_back({res, low_half});
                exp_last_q.push_back(c == out_ch - 1);
            end
        end
        if (out_ch % 2 == 1) begin
            exp_data_q.push_back({{RES_W{1'b0}}, low_half});
            exp_last_q.push_back(1'b1);
        end
        send_cmd(OP_COMPUTE, in_ch, out_ch);
        wait_not_busy();
        wait_results_done();
    endtask

    //////////////////////////////
    // stream processes
    initial begin : sender
        forever begin
            @(negedge clk);
            if (in_credit) begin
                in_credits++;
                credit_pulses++;
            end
            @(posedge clk);
            if (send_q.size() > 0 && in_credits > 0 && int'($urandom % 100) >= gap_pct) begin
                in_beat.valid <= 1'b1;
                in_beat.data  <= send_q.pop_front();
                in_credits--;
                words_sent++;
            end else begin
                in_beat.valid <= 1'b0;
            end
        end
    end

    initial begin : receiver
        forever begin
            @(negedge clk);
            if (out_beat.valid) begin
                words_rx++;
                owed++;
                rx_q.push_back(out_beat);
                if (words_rx > OUT_CREDITS + credits_granted) begin
                    flow_errs++;
                    $display("received %0d output words but only %0d credits were granted",
                             words_rx, OUT_CREDITS + credits_granted);
                end
            end
            @(posedge clk);
            if (stall_left > 0) begin
                stall_left--;
            end else if (stall_on != 0 && $urandom % 10 == 0) begin
                stall_left = 30 + int'($urandom % 70);
            end
            if (stall_left == 0 && owed > 0 && $urandom % 3 != 0) begin
                out_credit <= 1'b1;
                owed--;
                credits_granted++;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    initial begin : compare_words
        out_beat_t got;
        forever begin
            @(posedge clk);
            while (rx_q.size() > 0) begin
                got = rx_q.pop_front();
                if (exp_data_q.size() == 0) begin
                    flow_errs++;
                    $display("output word %h arrived with no result pending", got.data);
                end else begin
                    check_word(got, exp_data_q.pop_front());
                    check_last(got, exp_last_q.pop_front());
                end
            end
        end
    end

    //////////////////////////////
    // main sequence
    initial begin : main
        reset      = 1'b1;
        cmd        = '0;
        in_beat    = '0;
        out_credit = 1'b0;
        void'($urandom(32'h60cf));

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_low("busy_o", busy);
        check_low("in_credit_o", in_credit);
        check_low("out_o.valid", out_beat.valid);
        // quiet until the first command
        repeat (12) @(negedge clk);
        if (words_rx != 0) begin
            flow_errs++;
            $display("output words appeared before any command");
        end

        load_biases(6);
        run_layer(1 + int'($urandom % 8), 6, 0);
        // odd channel count
        load_biases(5);
        run_layer(3, 5, 0);
        // saturation both ways
        load_biases(4);
        run_layer(4, 4, 1);
        run_layer(1, 3, 1);

        // long credit stalls
        stall_on = 1;
        load_biases(20);
        run_layer(2, 20, 0);
        run_layer(3, 17, 0);
        stall_on = 0;

        // full speed followed by sparse input
        gap_pct = 0;
        run_layer(20, 3, 0);
        gap_pct = 60;
        run_layer(3, 6, 0);

        wait_not_busy();
        if (credit_pulses != words_sent) begin
            flow_errs++;
            $display("input credits returned %0d times for %0d words sent",
                     credit_pulses, words_sent);
        end
        if (send_q.size() != 0) begin
            flow_errs++;
            $display("%0d input words were never sent", send_q.size());
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/dp_pkg.sv
rtl/stream_fifo.sv
rtl/bias_ram.sv
rtl/channel_counter.sv
rtl/layer_ctrl_fsm.sv
rtl/psum_accum.sv
rtl/out_packer.sv
rtl/conv_data_path.sv
verification/conv_data_path_assert.sv
verification/tb_conv_data_path.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the conv_data_path testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_conv_data_path \
    -Mdir "$BUILD_DIR" -o sim_tb \
    -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation stopped with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    echo "test FAILED, see $LOG"
    exit 1
fi

echo "test passed"
exit 0
